// ==== logic/rv32i_pkg.sv ====
package rv32i_pkg;

    // base opcodes the front end cares about
    // jal is the only jump predicted here, jalr falls through
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    // field positions inside a 32-bit instruction word
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;

    // sequential step, no compressed instructions
    localparam logic [31:0] inst_bytes = 32'd4;

    // result of the predecoder for one fetched word
    typedef struct packed {
        // unconditional jal
        logic        is_jump;
        // any conditional branch (beq, bne, blt, bge, bltu, bgeu)
        logic        is_branch;
        // branch guessed taken, backward offset
        logic        predict_taken;
        // pc the predecoder wants fetched next
        logic [31:0] pc_next;
    } predecode_t;

endpackage : rv32i_pkg

// ==== logic/frontend_pkg.sv ====
package frontend_pkg;

    // data and address width
    localparam int xlen = 32;

    // first fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h6000_0000;

    // slots the rob reports per cycle at commit
    localparam int commit_slots = 2;

    // instruction queue entries between fetch and dispatch
    localparam int iq_depth = 8;

    // one fetched instruction with its address
    // pc sits in the upper half, word in the lower half
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_packet_t;

endpackage : frontend_pkg

// ==== logic/fetch_redirect_if.sv ====
interface fetch_redirect_if;
    import frontend_pkg::*;
    import rv32i_pkg::*;

    // consumed response that is kept, plus the word and its pc
    logic          fetch_valid;
    fetch_packet_t pkt;

    // predecode result for pkt, same cycle
    predecode_t    pd;

    // fetch stage owns the packet and picks the next pc from pd
    modport fetch  (output fetch_valid, output pkt, input pd);

    // predecoder looks at the packet only
    modport decode (input pkt, output pd);

    // queue stores kept packets
    modport queue  (input fetch_valid, input pkt);

endinterface : fetch_redirect_if

// ==== logic/fetch_stage.sv ====
module fetch_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                imem_resp,
    input  logic [frontend_pkg::xlen-1:0]       imem_rdata,
    output logic [frontend_pkg::xlen-1:0]       imem_addr,
    output logic                                imem_rmask,
    input  logic                                iq_full,
    input  logic [frontend_pkg::commit_slots-1:0] commit_valid,
    input  logic [frontend_pkg::commit_slots-1:0] commit_mispredict,
    input  logic [frontend_pkg::xlen-1:0]       commit_target [frontend_pkg::commit_slots],
    fetch_redirect_if.fetch                     fr
);
    import frontend_pkg::*;
    import rv32i_pkg::*;

    logic [xlen-1:0] pc_reg;
    logic [xlen-1:0] pc_seq;
    logic [xlen-1:0] redirect_pc;
    logic            redirect;
    logic            drop_pending;
    logic            consume;
    logic            take_pred;
    predecode_t      pd;

    assign pd = fr.pd;

    // memory may hand over a word only while the queue has room
    assign imem_rmask = !iq_full;
    assign imem_addr  = pc_reg;
    assign consume    = imem_resp && imem_rmask;
    assign pc_seq     = pc_reg + inst_bytes;

    // lowest mispredicting commit slot wins
    // walk downwards so the lowest match is written last
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        for (int i = commit_slots - 1; i >= 0; i--) begin
            if (commit_valid[i] && commit_mispredict[i]) begin
                redirect    = 1'b1;
                redirect_pc = commit_target[i];
            end
        end
    end

    // jal or backward branch that actually leaves the straight line
    assign take_pred = (pd.is_jump || (pd.is_branch && pd.predict_taken))
                       && (pd.pc_next != pc_seq);

    // word belongs to pc_reg unless it answers a request from before a redirect
    assign fr.fetch_valid = consume && !drop_pending;
    assign fr.pkt         = '{pc: pc_reg, inst: imem_rdata};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_reg       <= reset_pc;
            drop_pending <= 1'b0;
        end else if (redirect) begin
            pc_reg       <= redirect_pc;
            // old request still in flight unless it retires right now
            drop_pending <= !consume;
        end else if (consume) begin
            drop_pending <= 1'b0;
            // a stale word leaves pc on the redirect target
            if (!drop_pending) begin
                pc_reg <= take_pred ? pd.pc_next : pc_seq;
            end
        end
    end

    // address moves under a waiting word only when that word is marked stale
    addr_stable_while_waiting: assert property (@(posedge clk) disable iff (rst)
        (imem_resp && !imem_rmask) |=> ($stable(imem_addr) || drop_pending));

    // targets from commit and predecode are all word aligned
    pc_word_aligned: assert property (@(posedge clk) disable iff (rst)
        pc_reg[1:0] == 2'b00);

endmodule : fetch_stage

// ==== logic/predecode.sv ====
module predecode (
    fetch_redirect_if.decode fr
);
    import frontend_pkg::*;
    import rv32i_pkg::*;

    logic [6:0]      opcode;
    logic [xlen-1:0] inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] pc_seq;
    logic            is_jal;
    logic            is_br;
    logic            backward;

    assign inst   = fr.pkt.inst;
    assign pc     = fr.pkt.pc;
    assign opcode = inst[opcode_msb:opcode_lsb];
    assign pc_seq = pc + inst_bytes;

    assign is_jal = (opcode == opcode_jal);
    assign is_br  = (opcode == opcode_branch);

    // j-type offset with bit 0 always zero
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // b-type offset scattered around rd and funct3
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // loops branch backwards and usually repeat
    assign backward = imm_b[xlen-1];

    always_comb begin
        fr.pd.is_jump       = is_jal;
        fr.pd.is_branch     = is_br;
        fr.pd.predict_taken = is_br && backward;
        if (is_jal) begin
            fr.pd.pc_next = pc + imm_j;
        end else if (is_br && backward) begin
            fr.pd.pc_next = pc + imm_b;
        end else begin
            // forward branch, jalr and everything else go straight on
            fr.pd.pc_next = pc_seq;
        end
    end

endmodule : predecode

// ==== logic/inst_queue.sv ====
module inst_queue #(
    parameter int depth = frontend_pkg::iq_depth
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    fetch_redirect_if.queue               fr,
    output logic                          full,
    output logic                          inst_valid,
    output logic [frontend_pkg::xlen-1:0] inst_pc,
    output logic [frontend_pkg::xlen-1:0] inst_word,
    input  logic                          inst_ready
);
    import frontend_pkg::*;

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    fetch_packet_t entries [depth];
    ptr_t          wr_ptr;
    ptr_t          rd_ptr;
    cnt_t          count;
    logic          push;
    logic          pop;

    assign full = (count == cnt_t'(depth));

    // squashed entries must not leave during the flush cycle
    assign inst_valid = (count != '0) && !flush;
    assign inst_pc    = flush ? '0 : entries[rd_ptr].pc;
    assign inst_word  = flush ? '0 : entries[rd_ptr].inst;

    assign push = fr.fetch_valid && !full && !flush;
    assign pop  = inst_valid && inst_ready;

    // payload storage, the pointers say what is live
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= fr.pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // wrap by hand so depth need not be a power of two
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // fetch stage must hold the memory off while we are full
    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        fr.fetch_valid |-> !full);

    // a wrapped count would show up above depth
    no_count_underflow: assert property (@(posedge clk) disable iff (rst)
        count <= cnt_t'(depth));

endmodule : inst_queue

// ==== logic/frontend_top.sv ====
module frontend_top (
    input  logic                                  clk,
    input  logic                                  rst,
    // instruction memory
    output logic [frontend_pkg::xlen-1:0]         imem_addr,
    output logic                                  imem_rmask,
    input  logic                                  imem_resp,
    input  logic [frontend_pkg::xlen-1:0]         imem_rdata,
    // commit slots from the rob
    input  logic [frontend_pkg::commit_slots-1:0] commit_valid,
    input  logic [frontend_pkg::commit_slots-1:0] commit_mispredict,
    input  logic [frontend_pkg::xlen-1:0]         commit_target [frontend_pkg::commit_slots],
    // dispatch side
    output logic                                  inst_valid,
    output logic [frontend_pkg::xlen-1:0]         inst_pc,
    output logic [frontend_pkg::xlen-1:0]         inst_word,
    input  logic                                  inst_ready
);
    import frontend_pkg::*;

    logic [commit_slots-1:0] mispredict_hits;
    logic                    iq_flush;
    logic                    iq_full;

    fetch_redirect_if fr ();

    // any mispredicting slot squashes everything still queued
    assign mispredict_hits = commit_valid & commit_mispredict;
    assign iq_flush        = |mispredict_hits;

    fetch_stage u_fetch (
        .clk               (clk),
        .rst               (rst),
        .imem_resp         (imem_resp),
        .imem_rdata        (imem_rdata),
        .imem_addr         (imem_addr),
        .imem_rmask        (imem_rmask),
        .iq_full           (iq_full),
        .commit_valid      (commit_valid),
        .commit_mispredict (commit_mispredict),
        .commit_target     (commit_target),
        .fr                (fr.fetch)
    );

    // combinational, same cycle as the consumed word
    predecode u_predecode (
        .fr (fr.decode)
    );

    inst_queue #(
        .depth (iq_depth)
    ) u_queue (
        .clk        (clk),
        .rst        (rst),
        .flush      (iq_flush),
        .fr         (fr.queue),
        .full       (iq_full),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_word  (inst_word),
        .inst_ready (inst_ready)
    );

endmodule : frontend_top

// ==== tests/frontend_tb.sv ====
module frontend_tb;
    import frontend_pkg::*;

    localparam int reset_cycles = 16;
    localparam int test_count   = 6;
    localparam int test_cycles  = 400;
    // every test plus one spare test length and a little slack
    localparam int max_cycles   = (test_count + 1) * test_cycles + 200;

    logic                    clk;
    logic                    rst;
    logic [xlen-1:0]         imem_addr;
    logic                    imem_rmask;
    logic                    imem_resp;
    logic [xlen-1:0]         imem_rdata;
    logic [commit_slots-1:0] commit_valid;
    logic [commit_slots-1:0] commit_mispredict;
    logic [xlen-1:0]         commit_target [commit_slots];
    logic                    inst_valid;
    logic [xlen-1:0]         inst_pc;
    logic [xlen-1:0]         inst_word;
    logic                    inst_ready;

    // memory image plus the class (0 plain, 1 jal, 2 branch) and byte offset of each word
    logic [xlen-1:0] mem [256];
    int              ctl_kind [256];
    int              ctl_off [256];

    int seed = 32'ha614_d23a;
    int cycle_count = 0;
    int errors = 0;
    int checks = 0;
    int delivered = 0;
    int redirects = 0;
    int both_fired = 0;
    // current test knobs
    int cur_gap;
    int cur_pct;
    int cur_smax;
    bit cur_control;
    bit restart = 0;
    // memory model and consumer state
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] exp_pc = reset_pc;
    int              wait_cnt = 0;
    int              stall_left = 0;
    int              occupancy = 0;
    logic            req_start = 0;
    logic            drop_model = 0;
    logic            consumed = 0;
    logic            first_after_reset = 0;

    frontend_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop in case the run never reaches its end
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("run did not finish within %0d cycles", max_cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // where fetch should go after the word at pc
    function automatic logic [xlen-1:0] model_next(input logic [xlen-1:0] pc);
        int idx;
        idx = pc[9:2];
        // jal always jumps and a branch only when it points backwards
        if (ctl_kind[idx] == 1 || (ctl_kind[idx] == 2 && ctl_off[idx] < 0)) begin
            return pc + ctl_off[idx];
        end
        return pc + 4;
    endfunction

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0t %s", $time, what);
        end
    endtask

    task automatic fill_memory(input bit control);
        int          sel;
        int          off;
        logic [20:0] j;
        logic [12:0] b;
        for (int i = 0; i < 256; i++) begin
            // a quarter jal and a quarter branch when control words are wanted
            sel = control ? rand_below(4) : 3;
            off = (rand_below(8) + 1) * 4;
            if (rand_below(2) == 1) begin
                off = -off;
            end
            j = 21'(off);
            b = 13'(off);
            mem[i] = $random(seed);
            ctl_kind[i] = 0;
            ctl_off[i] = off;
            if (sel == 0) begin
                // j-type layout with a random rd
                mem[i] = {j[20], j[10:1], j[11], j[19:12], mem[i][11:7], 7'b1101111};
                ctl_kind[i] = 1;
            end else if (sel == 1) begin
                // b-type layout with random rs1 rs2 funct3
                mem[i] = {b[12], b[10:5], mem[i][24:12], b[4:1], b[11], 7'b1100011};
                ctl_kind[i] = 2;
            end else begin
                // op-imm is never a control transfer
                mem[i][6:0] = 7'b0010011;
            end
        end
    endtask

    task automatic drive_redirect();
        int s;
        for (int k = 0; k < commit_slots; k++) begin
            commit_target[k] = {reset_pc[xlen-1:10], 8'(rand_below(256)), 2'b00};
        end
        commit_valid      = commit_slots'(rand_below(1 << commit_slots));
        commit_mispredict = commit_slots'(rand_below(1 << commit_slots));
        // make sure at least one slot really mispredicts
        if ((commit_valid & commit_mispredict) == '0) begin
            s = rand_below(commit_slots);
            commit_valid[s]      = 1'b1;
            commit_mispredict[s] = 1'b1;
        end
        if (&(commit_valid & commit_mispredict)) begin
            both_fired++;
        end
        redirects++;
    endtask

    // memory, commit and consumer inputs driven 2 units after the rising edge
    task automatic drive_inputs();
        // a consumed response goes away and the next request starts this cycle
        if (consumed) begin
            imem_resp = 1'b0;
            req_start = 1'b1;
        end
        if (req_start) begin
            req_addr  = imem_addr;
            wait_cnt  = rand_below(4);
            req_start = 1'b0;
        end
        commit_valid      = '0;
        commit_mispredict = '0;
        if (restart) begin
            // the redirect squashes anything fetched from the old image
            fill_memory(cur_control);
            drive_redirect();
            restart = 0;
        end else if (cur_gap > 0 && rand_below(cur_gap) == 0) begin
            drive_redirect();
        end
        if (!imem_resp) begin
            if (wait_cnt == 0) begin
                imem_resp  = 1'b1;
                imem_rdata = mem[req_addr[9:2]];
            end else begin
                wait_cnt--;
            end
        end
        if (stall_left > 0) begin
            inst_ready = 1'b0;
            stall_left--;
        end else begin
            inst_ready = 1'b1;
            if (rand_below(100) < cur_pct) begin
                stall_left = 1 + rand_below(cur_smax);
            end
        end
    endtask

    // sample a cycle on the falling edge and drive the next one
    task automatic step();
        bit   found;
        logic redirect_seen;
        logic pop;
        @(negedge clk);
        consumed      = imem_resp && imem_rmask;
        redirect_seen = |(commit_valid & commit_mispredict);
        pop           = inst_valid && inst_ready;
        check(imem_rmask == (occupancy < iq_depth),
              $sformatf("imem_rmask %0b with %0d entries queued", imem_rmask, occupancy));
        // fetch holds the address the memory latched until that word is taken
        if (!drop_model) begin
            check(imem_addr == req_addr,
                  $sformatf("imem_addr %h, expected %h", imem_addr, req_addr));
        end
        if (first_after_reset) begin
            check(!inst_valid, "inst_valid high in the first cycle after reset");
            first_after_reset = 0;
        end
        if (redirect_seen) begin
            check(!inst_valid, "inst_valid high during a commit redirect");
            found = 0;
            for (int s = 0; s < commit_slots; s++) begin
                if (!found && commit_valid[s] && commit_mispredict[s]) begin
                    exp_pc = commit_target[s];
                    found  = 1;
                end
            end
            // the flush empties the queue and an outstanding word gets thrown away
            occupancy  = 0;
            drop_model = !consumed;
        end else begin
            if (pop) begin
                check(inst_pc == exp_pc,
                      $sformatf("inst_pc %h, expected %h", inst_pc, exp_pc));
                check(inst_word == mem[exp_pc[9:2]],
                      $sformatf("inst_word %h at %h, expected %h",
                                inst_word, exp_pc, mem[exp_pc[9:2]]));
                exp_pc = model_next(exp_pc);
                delivered++;
                occupancy--;
            end
            if (consumed && !drop_model) begin
                occupancy++;
            end
            if (consumed) begin
                drop_model = 0;
            end
        end
        @(posedge clk);
        #2;
        drive_inputs();
    endtask

    task automatic run_test(input int num, input string name, input bit control,
                            input int gap, input int pct, input int smax);
        int err0;
        int del0;
        err0        = errors;
        del0        = delivered;
        cur_control = control;
        cur_gap     = gap;
        cur_pct     = pct;
        cur_smax    = smax;
        if (num == 1) begin
            fill_memory(control);
            repeat (reset_cycles) begin
                @(posedge clk);
                #1;
                check(!inst_valid, "inst_valid high during reset");
            end
            #1;
            rst               = 1'b0;
            req_start         = 1'b1;
            first_after_reset = 1;
            drive_inputs();
        end else begin
            restart = 1;
        end
        repeat (test_cycles) begin
            step();
        end
        assert (delivered > del0) else begin
            errors++;
            $display("test %0d %s delivered no instructions", num, name);
        end
        $display("test %0d %s: %0d delivered, %0d errors",
                 num, name, delivered - del0, errors - err0);
    endtask

    initial begin
        rst               = 1'b1;
        imem_resp         = 1'b0;
        imem_rdata        = '0;
        commit_valid      = '0;
        commit_mispredict = '0;
        commit_target     = '{default: '0};
        inst_ready        = 1'b1;
        // name, control words, redirect gap, stall percent, longest stall
        run_test(1, "reset",        0, 0,  0,  1);
        run_test(2, "sequential",   0, 0,  10, 4);
        run_test(3, "prediction",   1, 0,  10, 4);
        run_test(4, "redirect",     1, 12, 10, 4);
        run_test(5, "backpressure", 1, 0,  15, 24);
        run_test(6, "mixed",        1, 40, 20, 12);
        $display("%0d tests, %0d checks, %0d errors, %0d redirects, %0d with both slots",
                 test_count, checks, errors, redirects, both_fired);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : frontend_tb

// ==== files.f ====
logic/rv32i_pkg.sv
logic/frontend_pkg.sv
logic/fetch_redirect_if.sv
logic/fetch_stage.sv
logic/predecode.sv
logic/inst_queue.sv
logic/frontend_top.sv
tests/frontend_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_frontend

sources:
  - logic/rv32i_pkg.sv
  - logic/frontend_pkg.sv
  - logic/fetch_redirect_if.sv
  - logic/fetch_stage.sv
  - logic/predecode.sv
  - logic/inst_queue.sv
  - logic/frontend_top.sv
  - target: test
    files:
      - tests/frontend_tb.sv
